// ==== tb/rp_analog_testdata.txt ====
# V loop | per channel: adc_mul adc_sum dac_mul dac_sum adc_pin(hex) asg | osc0 dac0(hex) osc1 dac1(hex)
# P level0 level1 level2 level3 ; D level hold_cycles
# gain 16384 is unity, pins and DAC codes are inverted offset binary
#
# unity and half gain with offsets
V 0  16384 0 16384 0 1c17 1000  8192 100 8192 -50 2bb7 2001  1000 1c17 -1400 1c49
# positive and negative saturation
V 0  32767 0 16384 8000 00bf 1000  32767 -100 -16384 0 3f3f 8191  8191 0000 -8192 3ffe
# floor rounding of negative products, zero gain
V 0  16383 0 12288 7 2000 -5  16384 -8192 0 8191 1fff 123  -1 1ffc -8192 0000
# loopback, ADC pins ignored
V 1  16384 0 16384 0 1234 2500  8192 10 16384 -500 0000 -1000  2500 163b -740 25db
V 1  24576 0 16384 0 3fff 7000  16384 1 8192 0 1fff -3  8191 04a7 -1 2001
# back to ADC path after loopback
V 0  16384 0 16384 0 1c17 1000  8192 100 8192 -50 2bb7 2001  1000 1c17 -1400 1c49
#
# pdm levels including both ends
P 0 1 128 255
P 254 37 200 3
P 255 255 0 0
#
# debounce, DEB_LEN 16 in this bench
# short glitch then back low
D 1 5
D 0 30
# held rise
D 1 30
# glitch low while high
D 0 6
D 1 30
# held fall
D 0 30

// ==== rp_analog.f ====
rtl/rp_analog_pkg.sv
rtl/linear_calib.sv
rtl/adc_channel.sv
rtl/dac_channel.sv
rtl/debounce.sv
rtl/pdm.sv
rtl/rp_analog_top.sv
tb/rp_analog_checker.sv
tb/rp_analog_tb.sv

// ==== Bender.yml ====
package:
  name: rp_analog

sources:
  - files:
      - rtl/rp_analog_pkg.sv
      - rtl/linear_calib.sv
      - rtl/adc_channel.sv
      - rtl/dac_channel.sv
      - rtl/debounce.sv
      - rtl/pdm.sv
      - rtl/rp_analog_top.sv
  - target: test
    files:
      - tb/rp_analog_checker.sv
      - tb/rp_analog_tb.sv

// ==== tb/rp_analog_tb.sv ====
// analog front end testbench
`timescale 1ns/1ps

module rp_analog_tb;

  localparam int CHN_NUM = 2;
  localparam int PDM_CHN = 4;
  localparam int DEB_LEN = 16;
  // cycles per case kind
  localparam int VEC_CYC = 8;
  localparam int PDM_CYC = 280;

  logic adc_clk;
  logic top_rst;
  logic [CHN_NUM-1:0] [14-1:0] adc_dat;
  logic digital_loop;
  rp_analog_pkg::calib_mul_t [CHN_NUM-1:0] adc_mul;
  rp_analog_pkg::calib_sum_t [CHN_NUM-1:0] adc_sum;
  rp_analog_pkg::calib_mul_t [CHN_NUM-1:0] dac_mul;
  rp_analog_pkg::calib_sum_t [CHN_NUM-1:0] dac_sum;
  rp_analog_pkg::sample_t [CHN_NUM-1:0] asg_dat;
  rp_analog_pkg::sample_t [CHN_NUM-1:0] osc_dat;
  logic [CHN_NUM-1:0] [14-1:0] dac_dat;
  rp_analog_pkg::pdm_t [PDM_CHN-1:0] pdm_cfg;
  logic [PDM_CHN-1:0] pdm_out;
  logic dig_in;
  logic dig_out;
  logic trg_pos;
  logic trg_neg;

  // checker control
  logic rst_chk;
  logic vec_chk;
  logic pdm_go;
  logic deb_chk;
  rp_analog_pkg::sample_t [CHN_NUM-1:0] exp_osc;
  logic [CHN_NUM-1:0] [14-1:0] exp_dac;
  int exp_pos;
  int exp_neg;
  int exp_lvl;
  int chk_err;

  string lines[$];
  int tb_err;
  int cyc;
  int cyc_limit;
  int deb_state;

  rp_analog_top #(
    .CHN_NUM (CHN_NUM),
    .PDM_CHN (PDM_CHN),
    .DEB_CW  (20),
    .DEB_LEN (DEB_LEN)
  ) u_dut (
    .adc_clk        (adc_clk),
    .top_rst        (top_rst),
    .adc_dat_i      (adc_dat),
    .digital_loop_i (digital_loop),
    .adc_mul_i      (adc_mul),
    .adc_sum_i      (adc_sum),
    .dac_mul_i      (dac_mul),
    .dac_sum_i      (dac_sum),
    .asg_dat_i      (asg_dat),
    .osc_dat_o      (osc_dat),
    .dac_dat_o      (dac_dat),
    .pdm_cfg_i      (pdm_cfg),
    .pdm_o          (pdm_out),
    .dig_i          (dig_in),
    .dig_o          (dig_out),
    .trg_pos_o      (trg_pos),
    .trg_neg_o      (trg_neg)
  );

  rp_analog_checker #(
    .CHN_NUM (CHN_NUM),
    .PDM_CHN (PDM_CHN),
    .DEB_LEN (DEB_LEN)
  ) u_chk (
    .adc_clk      (adc_clk),
    .top_rst      (top_rst),
    .adc_dat_i    (adc_dat),
    .digital_loop_i (digital_loop),
    .adc_mul_i    (adc_mul),
    .adc_sum_i    (adc_sum),
    .dac_mul_i    (dac_mul),
    .dac_sum_i    (dac_sum),
    .asg_dat_i    (asg_dat),
    .osc_dat_i    (osc_dat),
    .dac_dat_i    (dac_dat),
    .pdm_cfg_i    (pdm_cfg),
    .pdm_i        (pdm_out),
    .dig_in_i     (dig_in),
    .dig_out_i    (dig_out),
    .trg_pos_i    (trg_pos),
    .trg_neg_i    (trg_neg),
    .rst_chk_i    (rst_chk),
    .vec_chk_i    (vec_chk),
    .exp_osc_i    (exp_osc),
    .exp_dac_i    (exp_dac),
    .pdm_go_i     (pdm_go),
    .deb_chk_i    (deb_chk),
    .exp_pos_i    (exp_pos),
    .exp_neg_i    (exp_neg),
    .exp_lvl_i    (exp_lvl),
    .err_cnt_o    (chk_err)
  );

  ////////////////////
  // clock and timeout
  ////////////////////

  initial begin
    adc_clk = 1'b0;
    forever #4 adc_clk = ~adc_clk;
  end

  initial begin
    cyc = 0;
    forever begin
      @(posedge adc_clk);
      cyc++;
    end
  end

  // limit is known once the data file is read
  initial begin
    wait (cyc_limit > 0);
    while (cyc < cyc_limit) @(posedge adc_clk);
    $display("timeout: run did not finish within %0d cycles", cyc_limit);
    $display("CHECKS FAILED");
    $finish;
  end

  ////////////////////
  // data file
  ////////////////////

  // returns 0 when the file cannot be opened
  function automatic int load_data();
    int fd;
    int n;
    string line;
    fd = $fopen("tb/rp_analog_testdata.txt", "r");
    if (fd == 0) return 0;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // skip comments and blank lines
      if (n > 1 && line[0] != "#") lines.push_back(line);
    end
    $fclose(fd);
    return 1;
  endfunction

  // cycles a case line occupies
  function automatic int case_cycles(string line);
    string kind;
    int lvl;
    int hold;
    int n;
    n = $sscanf(line, "%s %d %d", kind, lvl, hold);
    if (kind == "V") return VEC_CYC;
    if (kind == "P") return PDM_CYC;
    if (kind == "D" && n == 3) return hold;
    return 0;
  endfunction

  ////////////////////
  // case drivers
  ////////////////////

  task automatic apply_vector(string line);
    string kind;
    int f[17];
    int n;
    n = $sscanf(line, "%s %d %d %d %d %d %h %d %d %d %d %d %h %d %d %h %d %h", kind,
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                f[11], f[12], f[13], f[14], f[15], f[16]);
    if (n != 18) begin
      $display("malformed vector line in test data: %s", line);
      tb_err++;
      return;
    end
    digital_loop = f[0][0];
    // six fields per channel, then two expected values per channel
    for (int c = 0; c < CHN_NUM; c++) begin
      adc_mul[c] = f[1+6*c];
      adc_sum[c] = f[2+6*c];
      dac_mul[c] = f[3+6*c];
      dac_sum[c] = f[4+6*c];
      adc_dat[c] = f[5+6*c];
      asg_dat[c] = f[6+6*c];
      exp_osc[c] = f[13+2*c];
      exp_dac[c] = f[14+2*c];
    end
    // sample on the last held cycle
    repeat (VEC_CYC - 1) @(negedge adc_clk);
    vec_chk = 1'b1;
    @(negedge adc_clk);
    vec_chk = 1'b0;
  endtask

  task automatic set_pdm_levels(string line);
    string kind;
    int l[4];
    int n;
    n = $sscanf(line, "%s %d %d %d %d", kind, l[0], l[1], l[2], l[3]);
    if (n != 5) begin
      $display("malformed pdm line in test data: %s", line);
      tb_err++;
      return;
    end
    for (int i = 0; i < PDM_CHN; i++) pdm_cfg[i] = l[i];
    // checker starts its window on the same edge
    pdm_go = 1'b1;
    @(negedge adc_clk);
    pdm_go = 1'b0;
    repeat (PDM_CYC - 1) @(negedge adc_clk);
  endtask

  task automatic hold_dig_level(string line);
    string kind;
    int lvl;
    int hold;
    int n;
    n = $sscanf(line, "%s %d %d", kind, lvl, hold);
    if (n != 3 || hold < 2) begin
      $display("malformed debounce line in test data: %s", line);
      tb_err++;
      return;
    end
    exp_pos = 0;
    exp_neg = 0;
    // flip only when held past the full latency
    if (lvl != deb_state && hold >= DEB_LEN + 6) begin
      if (lvl != 0) exp_pos = 1;
      else exp_neg = 1;
      deb_state = lvl;
    end
    exp_lvl = deb_state;
    dig_in = lvl[0];
    repeat (hold - 1) @(negedge adc_clk);
    deb_chk = 1'b1;
    @(negedge adc_clk);
    deb_chk = 1'b0;
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    int total;
    string kind;
    int n;
    top_rst = 1'b1;
    // pin code of sample 0
    adc_dat = {CHN_NUM{14'h1fff}};
    digital_loop = 1'b0;
    adc_mul = '0;
    adc_sum = '0;
    dac_mul = '0;
    dac_sum = '0;
    asg_dat = '0;
    pdm_cfg = '0;
    dig_in = 1'b0;
    rst_chk = 1'b0;
    vec_chk = 1'b0;
    pdm_go = 1'b0;
    deb_chk = 1'b0;
    exp_osc = '0;
    exp_dac = '0;
    exp_pos = 0;
    exp_neg = 0;
    exp_lvl = 0;
    tb_err = 0;
    cyc_limit = 0;
    deb_state = 0;
    if (load_data() == 0) begin
      $display("could not open test data file tb/rp_analog_testdata.txt");
      $display("CHECKS FAILED");
      $finish;
    end else begin
      total = 8;
      foreach (lines[i]) total += case_cycles(lines[i]);
      cyc_limit = total + total / 5 + 100;
      // reset state is checked on the last reset cycle
      repeat (7) @(negedge adc_clk);
      rst_chk = 1'b1;
      @(negedge adc_clk);
      rst_chk = 1'b0;
      top_rst = 1'b0;
      foreach (lines[i]) begin
        n = $sscanf(lines[i], "%s", kind);
        if (n != 1) begin
          $display("unreadable line in test data: %s", lines[i]);
          tb_err++;
        end else if (kind == "V") apply_vector(lines[i]);
        else if (kind == "P") set_pdm_levels(lines[i]);
        else if (kind == "D") hold_dig_level(lines[i]);
        else begin
          $display("unknown line kind in test data: %s", lines[i]);
          tb_err++;
        end
      end
      repeat (2) @(negedge adc_clk);
      $display("run complete, %0d checker errors, %0d data errors", chk_err, tb_err);
      if (chk_err == 0 && tb_err == 0) begin
        $display("ALL CHECKS PASSED");
      end else begin
        $display("CHECKS FAILED");
      end
      $finish;
    end
  end

endmodule: rp_analog_tb

// ==== tb/rp_analog_checker.sv ====
// analog front end output checker
`timescale 1ns/1ps

module rp_analog_checker #(
  int CHN_NUM = 2,
  int PDM_CHN = 4,
  int DEB_LEN = 16
)(
  input logic adc_clk,
  input logic top_rst,
  // DUT inputs
  input logic [CHN_NUM-1:0] [14-1:0] adc_dat_i,
  input logic digital_loop_i,
  input rp_analog_pkg::calib_mul_t [CHN_NUM-1:0] adc_mul_i,
  input rp_analog_pkg::calib_sum_t [CHN_NUM-1:0] adc_sum_i,
  input rp_analog_pkg::calib_mul_t [CHN_NUM-1:0] dac_mul_i,
  input rp_analog_pkg::calib_sum_t [CHN_NUM-1:0] dac_sum_i,
  input rp_analog_pkg::sample_t [CHN_NUM-1:0] asg_dat_i,
  // DUT outputs
  input rp_analog_pkg::sample_t [CHN_NUM-1:0] osc_dat_i,
  input logic [CHN_NUM-1:0] [14-1:0] dac_dat_i,
  input rp_analog_pkg::pdm_t [PDM_CHN-1:0] pdm_cfg_i,
  input logic [PDM_CHN-1:0] pdm_i,
  input logic dig_in_i,
  input logic dig_out_i,
  input logic trg_pos_i,
  input logic trg_neg_i,
  // strobes and expected values from the testbench
  input logic rst_chk_i,
  input logic vec_chk_i,
  input rp_analog_pkg::sample_t [CHN_NUM-1:0] exp_osc_i,
  input logic [CHN_NUM-1:0] [14-1:0] exp_dac_i,
  input logic pdm_go_i,
  input logic deb_chk_i,
  input int exp_pos_i,
  input int exp_neg_i,
  input int exp_lvl_i,
  output int err_cnt_o
);

  int pdm_cyc;
  int pdm_ones[PDM_CHN];
  int since;
  int pos_cnt;
  int neg_cnt;
  logic dig_prev;

  // multiply, floor shift, offset, clamp
  function automatic int calib_ref(int x, int m, int o);
    longint p;
    longint s;
    p = longint'(x) * longint'(m);
    s = (p >>> rp_analog_pkg::CALIB_SHIFT) + o;
    if (s > rp_analog_pkg::SAMPLE_MAX) s = rp_analog_pkg::SAMPLE_MAX;
    if (s < rp_analog_pkg::SAMPLE_MIN) s = rp_analog_pkg::SAMPLE_MIN;
    return int'(s);
  endfunction

  // bit 13 kept, bits 12..0 inverted
  function automatic logic [13:0] flip_low(logic [13:0] v);
    return v ^ 14'h1fff;
  endfunction

  function automatic void report(string msg);
    $display("error at %0t: %s", $time, msg);
    err_cnt_o++;
  endfunction

  initial begin
    err_cnt_o = 0;
    pdm_cyc = -1;
    since = 0;
    pos_cnt = 0;
    neg_cnt = 0;
    dig_prev = 1'b0;
  end

  ////////////////////
  // reset and vectors
  ////////////////////

  always @(posedge adc_clk) begin
    int ref_dac;
    int ref_osc;
    logic [13:0] ref_code;
    if (rst_chk_i) begin
      if (osc_dat_i != '0) report("osc_dat_o not 0 in reset");
      if (dac_dat_i != {CHN_NUM{14'h1fff}}) report("dac_dat_o not 8191 in reset");
      if (pdm_i != '0 || dig_out_i || trg_pos_i || trg_neg_i)
        report("pdm or debounce outputs not 0 in reset");
    end
    if (vec_chk_i) begin
      for (int c = 0; c < CHN_NUM; c++) begin
        ref_dac = calib_ref(asg_dat_i[c], dac_mul_i[c], dac_sum_i[c]);
        if (digital_loop_i) ref_osc = calib_ref(ref_dac, adc_mul_i[c], adc_sum_i[c]);
        else ref_osc = calib_ref($signed(flip_low(adc_dat_i[c])), adc_mul_i[c], adc_sum_i[c]);
        ref_code = flip_low(ref_dac[13:0]);
        if (osc_dat_i[c] != exp_osc_i[c])
          report($sformatf("ch%0d osc_dat_o %0d, file expects %0d", c, osc_dat_i[c],
                           exp_osc_i[c]));
        if (osc_dat_i[c] != ref_osc)
          report($sformatf("ch%0d osc_dat_o %0d, rules give %0d", c, osc_dat_i[c], ref_osc));
        if (dac_dat_i[c] != exp_dac_i[c])
          report($sformatf("ch%0d dac_dat_o %h, file expects %h", c, dac_dat_i[c],
                           exp_dac_i[c]));
        if (dac_dat_i[c] != ref_code)
          report($sformatf("ch%0d dac_dat_o %h, rules give %h", c, dac_dat_i[c], ref_code));
      end
    end
  end

  ////////////////////
  // pdm density
  ////////////////////

  // 20 settling cycles, then one full period
  always @(posedge adc_clk) begin
    if (pdm_go_i) begin
      pdm_cyc = 0;
      foreach (pdm_ones[i]) pdm_ones[i] = 0;
    end else if (pdm_cyc >= 0) begin
      pdm_cyc++;
      if (pdm_cyc > 20 && pdm_cyc <= 20 + rp_analog_pkg::PDM_RNG) begin
        for (int i = 0; i < PDM_CHN; i++) pdm_ones[i] += pdm_i[i];
      end else if (pdm_cyc > 20 + rp_analog_pkg::PDM_RNG) begin
        for (int i = 0; i < PDM_CHN; i++) begin
          if (pdm_ones[i] != pdm_cfg_i[i])
            report($sformatf("pdm_o[%0d] gave %0d ones, level %0d", i, pdm_ones[i],
                             pdm_cfg_i[i]));
        end
        pdm_cyc = -1;
      end
    end
  end

  ////////////////////
  // debounce
  ////////////////////

  always @(posedge adc_clk) begin
    if (!top_rst) begin
      if (dig_in_i != dig_prev) since = 0;
      else if (since < 1000000) since++;
      dig_prev = dig_in_i;
      if (trg_pos_i || trg_neg_i) begin
        if (since < DEB_LEN + 2 || since > DEB_LEN + 4)
          report($sformatf("trigger pulse %0d cycles after input change", since));
        if (trg_pos_i) pos_cnt++;
        if (trg_neg_i) neg_cnt++;
      end
      if (deb_chk_i) begin
        if (pos_cnt != exp_pos_i || neg_cnt != exp_neg_i)
          report($sformatf("pulses pos %0d neg %0d, expected pos %0d neg %0d", pos_cnt,
                           neg_cnt, exp_pos_i, exp_neg_i));
        if (dig_out_i != exp_lvl_i[0])
          report($sformatf("dig_o %0b, expected %0d", dig_out_i, exp_lvl_i));
        pos_cnt = 0;
        neg_cnt = 0;
      end
    end
  end

endmodule: rp_analog_checker

// ==== rtl/rp_analog_top.sv ====
// analog front end top level
`timescale 1ns/1ps

module rp_analog_top #(
  // ADC and DAC channel count
  int unsigned CHN_NUM = 2,
  // pdm output count
  int unsigned PDM_CHN = 4,
  // debounce counter width and length
  int unsigned DEB_CW  = 20,
  int unsigned DEB_LEN = 62500
)(
  // clock and reset
  input  logic                                      adc_clk,
  input  logic                                      top_rst,
  // ADC side
  input  logic                      [CHN_NUM-1:0] [14-1:0] adc_dat_i,
  input  logic                                      digital_loop_i,
  // calibration
  input  rp_analog_pkg::calib_mul_t [CHN_NUM-1:0]   adc_mul_i,
  input  rp_analog_pkg::calib_sum_t [CHN_NUM-1:0]   adc_sum_i,
  input  rp_analog_pkg::calib_mul_t [CHN_NUM-1:0]   dac_mul_i,
  input  rp_analog_pkg::calib_sum_t [CHN_NUM-1:0]   dac_sum_i,
  // generator side
  input  rp_analog_pkg::sample_t    [CHN_NUM-1:0]   asg_dat_i,
  // acquisition samples and DAC codes
  output rp_analog_pkg::sample_t    [CHN_NUM-1:0]   osc_dat_o,
  output logic                      [CHN_NUM-1:0] [14-1:0] dac_dat_o,
  // pdm
  input  rp_analog_pkg::pdm_t       [PDM_CHN-1:0]   pdm_cfg_i,
  output logic                      [PDM_CHN-1:0]   pdm_o,
  // debounced trigger input
  input  logic                                      dig_i,
  output logic                                      dig_o,
  output logic                                      trg_pos_o,
  output logic                                      trg_neg_o
);

  //////////////////////
  // converter channels
  //////////////////////

  // calibrated DAC samples, fed back for loopback
  rp_analog_pkg::sample_t [CHN_NUM-1:0] loop_dat;

  for (genvar i = 0; i < CHN_NUM; i++) begin: gen_chn

    // generation path
    dac_channel u_dac (
      .adc_clk    (adc_clk),
      .top_rst    (top_rst),
      .asg_dat_i  (asg_dat_i[i]),
      .cfg_mul_i  (dac_mul_i[i]),
      .cfg_sum_i  (dac_sum_i[i]),
      .loop_dat_o (loop_dat[i]),
      .dac_dat_o  (dac_dat_o[i])
    );

    // acquisition path, same index loopback
    adc_channel u_adc (
      .adc_clk        (adc_clk),
      .top_rst        (top_rst),
      .adc_dat_i      (adc_dat_i[i]),
      .loop_dat_i     (loop_dat[i]),
      .digital_loop_i (digital_loop_i),
      .cfg_mul_i      (adc_mul_i[i]),
      .cfg_sum_i      (adc_sum_i[i]),
      .osc_dat_o      (osc_dat_o[i])
    );

  end: gen_chn

  //////////////////////
  // misc outputs
  //////////////////////

  // trigger input
  debounce #(
    .DEB_CW  (DEB_CW),
    .DEB_LEN (DEB_LEN)
  ) u_debounce (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .dig_i     (dig_i),
    .dig_o     (dig_o),
    .trg_pos_o (trg_pos_o),
    .trg_neg_o (trg_neg_o)
  );

  // slow analog outputs
  pdm #(
    .PDM_CHN (PDM_CHN)
  ) u_pdm (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .pdm_cfg_i (pdm_cfg_i),
    .pdm_o     (pdm_o)
  );

endmodule: rp_analog_top

// ==== rtl/pdm.sv ====
// first order pulse density modulator bank
`timescale 1ns/1ps

module pdm #(
  // number of outputs
  int unsigned PDM_CHN = 4
)(
  // clock and reset
  input  logic                                adc_clk,
  input  logic                                top_rst,
  // level per output
  input  rp_analog_pkg::pdm_t [PDM_CHN-1:0]   pdm_cfg_i,
  // modulated outputs
  output logic                [PDM_CHN-1:0]   pdm_o
);

  // one bit wider than a level, holds acc plus level
  localparam int AW = $bits(rp_analog_pkg::pdm_t) + 1;

  for (genvar i = 0; i < PDM_CHN; i++) begin: gen_chn

    logic [AW-1:0] acc;
    logic [AW-1:0] acc_sum;
    logic          acc_ovf;

    // acc stays below PDM_RNG between cycles
    assign acc_sum = acc + pdm_cfg_i[i];
    assign acc_ovf = acc_sum >= AW'(rp_analog_pkg::PDM_RNG);

    // emit a one and drop one period on overflow
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        acc      <= '0;
        pdm_o[i] <= 1'b0;
      end else if (acc_ovf) begin
        acc      <= acc_sum - AW'(rp_analog_pkg::PDM_RNG);
        pdm_o[i] <= 1'b1;
      end else begin
        acc      <= acc_sum;
        pdm_o[i] <= 1'b0;
      end
    end

  end: gen_chn

endmodule: pdm

// ==== rtl/debounce.sv ====
// digital input debouncer
`timescale 1ns/1ps

module debounce #(
  // counter width
  int unsigned DEB_CW  = 20,
  // stable length in cycles
  int unsigned DEB_LEN = 62500
)(
  // clock and reset
  input  logic adc_clk,
  input  logic top_rst,
  // raw asynchronous input
  input  logic dig_i,
  // debounced level
  output logic dig_o,
  // edge pulses, one cycle each
  output logic trg_pos_o,
  output logic trg_neg_o
);

  logic [2-1:0]      dig_sync;
  logic [DEB_CW-1:0] cnt;
  logic              flip;

  // 2 flop synchronizer
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dig_sync <= '0;
    end else begin
      dig_sync <= {dig_sync[0], dig_i};
    end
  end

  // last disagreeing cycle of the run
  assign flip = (dig_sync[1] != dig_o) && (cnt == DEB_CW'(DEB_LEN - 1));

  //////////////////////
  // stability counter
  //////////////////////

  // counts cycles the input differs from the level
  // any agreement restarts the count
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      cnt <= '0;
    end else if ((dig_sync[1] == dig_o) || flip) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // level flip and the matching edge pulse
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dig_o     <= 1'b0;
      trg_pos_o <= 1'b0;
      trg_neg_o <= 1'b0;
    end else begin
      dig_o     <= flip ? ~dig_o : dig_o;
      trg_pos_o <= flip & ~dig_o;
      trg_neg_o <= flip &  dig_o;
    end
  end

endmodule: debounce

// ==== rtl/dac_channel.sv ====
// DAC generation channel
`timescale 1ns/1ps

module dac_channel (
  // clock and reset
  input  logic                      adc_clk,
  input  logic                      top_rst,
  // generator sample
  input  rp_analog_pkg::sample_t    asg_dat_i,
  // calibration
  input  rp_analog_pkg::calib_mul_t cfg_mul_i,
  input  rp_analog_pkg::calib_sum_t cfg_sum_i,
  // calibrated sample for loopback
  output rp_analog_pkg::sample_t    loop_dat_o,
  // DAC code, inverted offset binary
  output logic [14-1:0]             dac_dat_o
);

  rp_analog_pkg::sample_t dac_cal;

  // generation calibration, 2 cycles
  linear_calib u_calib (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .sti_dat_i (asg_dat_i),
    .cfg_mul_i (cfg_mul_i),
    .cfg_sum_i (cfg_sum_i),
    .sto_dat_o (dac_cal)
  );

  // loopback taps the calibrated sample before formatting
  assign loop_dat_o = dac_cal;

  // output format register
  // sample 0 maps to code 8191 (negative slope)
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_dat_o <= {1'b0, {13{1'b1}}};
    end else begin
      dac_dat_o <= {dac_cal[14-1], ~dac_cal[14-2:0]};
    end
  end

endmodule: dac_channel

// ==== rtl/adc_channel.sv ====
// ADC acquisition channel
`timescale 1ns/1ps

module adc_channel (
  // clock and reset
  input  logic                      adc_clk,
  input  logic                      top_rst,
  // ADC pins, inverted offset binary
  input  logic [14-1:0]             adc_dat_i,
  // calibrated DAC sample of this channel
  input  rp_analog_pkg::sample_t    loop_dat_i,
  input  logic                      digital_loop_i,
  // calibration
  input  rp_analog_pkg::calib_mul_t cfg_mul_i,
  input  rp_analog_pkg::calib_sum_t cfg_sum_i,
  // calibrated sample to acquisition
  output rp_analog_pkg::sample_t    osc_dat_o
);

  rp_analog_pkg::sample_t adc_raw;
  rp_analog_pkg::sample_t adc_sel;

  // pin capture register
  // msb kept, remaining bits inverted gives two's complement
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      adc_raw <= '0;
    end else begin
      adc_raw <= {adc_dat_i[14-1], ~adc_dat_i[14-2:0]};
    end
  end

  // digital loopback mux
  // loop sample bypasses the capture register
  assign adc_sel = digital_loop_i ? loop_dat_i : adc_raw;

  // acquisition calibration, 2 cycles
  linear_calib u_calib (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .sti_dat_i (adc_sel),
    .cfg_mul_i (cfg_mul_i),
    .cfg_sum_i (cfg_sum_i),
    .sto_dat_o (osc_dat_o)
  );

endmodule: adc_channel

// ==== rtl/linear_calib.sv ====
// linear gain and offset stage
`timescale 1ns/1ps

module linear_calib (
  // clock and reset
  input  logic                      adc_clk,
  input  logic                      top_rst,
  // sample stream in
  input  rp_analog_pkg::sample_t    sti_dat_i,
  // calibration
  input  rp_analog_pkg::calib_mul_t cfg_mul_i,
  input  rp_analog_pkg::calib_sum_t cfg_sum_i,
  // sample stream out
  output rp_analog_pkg::sample_t    sto_dat_o
);

  // full product width
  localparam int MW = $bits(rp_analog_pkg::sample_t) + $bits(rp_analog_pkg::calib_mul_t);
  // width left after the shift
  localparam int SW = MW - rp_analog_pkg::CALIB_SHIFT;

  logic signed [MW-1:0] mul_full;
  logic signed [SW-1:0] mul_shr;
  logic signed [SW:0]   sum_full;

  ////////////////////
  // stage one
  ////////////////////

  // signed multiply, both operands sign extended
  assign mul_full = sti_dat_i * cfg_mul_i;

  // dropping low bits is an arithmetic shift
  // rounds toward minus infinity
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      mul_shr <= '0;
    end else begin
      mul_shr <= mul_full[MW-1:rp_analog_pkg::CALIB_SHIFT];
    end
  end

  ////////////////////
  // stage two
  ////////////////////

  // one extra bit so the sum cannot wrap
  assign sum_full = mul_shr + cfg_sum_i;

  // clamp to sample range
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      sto_dat_o <= '0;
    end else if (sum_full > rp_analog_pkg::SAMPLE_MAX) begin
      sto_dat_o <= rp_analog_pkg::sample_t'(rp_analog_pkg::SAMPLE_MAX);
    end else if (sum_full < rp_analog_pkg::SAMPLE_MIN) begin
      sto_dat_o <= rp_analog_pkg::sample_t'(rp_analog_pkg::SAMPLE_MIN);
    end else begin
      sto_dat_o <= sum_full[$bits(rp_analog_pkg::sample_t)-1:0];
    end
  end

endmodule: linear_calib

// ==== rtl/rp_analog_pkg.sv ====
// analog front end shared types
package rp_analog_pkg;

  //////////////////////
  // converter samples
  //////////////////////

  // signed sample, same width on ADC and DAC side
  typedef logic signed [14-1:0] sample_t;

  // saturation limits of a sample
  localparam int SAMPLE_MAX = 8191;
  localparam int SAMPLE_MIN = -8192;

  //////////////////////
  // calibration
  //////////////////////

  // gain, 1.0 equals CALIB_UNITY
  typedef logic signed [16-1:0] calib_mul_t;
  // offset, added after scaling
  typedef logic signed [14-1:0] calib_sum_t;

  // product is shifted right by this many bits
  localparam int CALIB_SHIFT = 14;
  localparam int CALIB_UNITY = 16384;

  //////////////////////
  // pdm outputs
  //////////////////////

  // one pdm level, unsigned
  typedef logic [8-1:0] pdm_t;

  // accumulator period
  localparam int PDM_RNG = 255;

endpackage: rp_analog_pkg
